/* include/mips_macros.svh */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// data path and address width
`define MIPS_XLEN 32

// register index width, 32 general registers
`define MIPS_REG_AW 5

// one strobe bit per byte lane of a word
`define MIPS_STRB_W 4

// first fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

// jal writes its return address here
`define MIPS_LINK_REG 5'd31

`endif

/* verilog/mips_pkg.sv */
`default_nettype none
`include "mips_macros.svh"

package mips_pkg;

	// fsm states, one hot
	typedef enum logic [8:0] {
		st_rst = 9'b0_0000_0001,
		st_if  = 9'b0_0000_0010,
		st_iw  = 9'b0_0000_0100,
		st_id  = 9'b0_0000_1000,
		st_ex  = 9'b0_0001_0000,
		st_ld  = 9'b0_0010_0000,
		st_st  = 9'b0_0100_0000,
		st_rdw = 9'b0_1000_0000,
		st_wb  = 9'b1_0000_0000
	} state_t;

	// major opcodes of the supported subset
	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_j       = 6'h02,
		op_jal     = 6'h03,
		op_beq     = 6'h04,
		op_bne     = 6'h05,
		op_addiu   = 6'h09,
		op_slti    = 6'h0a,
		op_sltiu   = 6'h0b,
		op_andi    = 6'h0c,
		op_ori     = 6'h0d,
		op_xori    = 6'h0e,
		op_lui     = 6'h0f,
		op_lb      = 6'h20,
		op_lh      = 6'h21,
		op_lw      = 6'h23,
		op_lbu     = 6'h24,
		op_lhu     = 6'h25,
		op_sb      = 6'h28,
		op_sh      = 6'h29,
		op_sw      = 6'h2b
	} opcode_t;

	// function field of op_special
	typedef enum logic [5:0] {
		fn_jr   = 6'h08,
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_xor  = 6'h26,
		fn_nor  = 6'h27,
		fn_slt  = 6'h2a,
		fn_sltu = 6'h2b
	} funct_t;

	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor, alu_slt, alu_sltu
	} alu_op_t;

	// write-back source
	typedef enum logic [1:0] {
		wb_alu, wb_load, wb_upper
	} wb_sel_t;

	typedef enum logic [1:0] {
		size_byte, size_half, size_word
	} mem_size_t;

	// everything later stages need from one instruction word
	typedef struct packed {
		opcode_t                 opcode;
		logic [`MIPS_REG_AW-1:0] rs;
		logic [`MIPS_REG_AW-1:0] rt;
		logic [15:0]             imm16;
		logic [25:0]             jump_index;
		alu_op_t                 alu_op;
		logic                    b_from_imm;
		logic                    zero_ext;
		logic                    link;
		logic                    wb_en;
		logic [`MIPS_REG_AW-1:0] wb_addr;
		wb_sel_t                 wb_sel;
		logic                    is_load;
		logic                    is_store;
		logic                    is_branch;
		logic                    branch_ne;
		logic                    is_jump;
		logic                    jump_reg;
		mem_size_t               mem_size;
		logic                    mem_unsigned;
		logic                    is_nop;
	} decoded_t;

	// data channel request, 70 bits
	typedef struct packed {
		logic                    read;
		logic                    write;
		logic [`MIPS_XLEN-1:0]   address;
		logic [`MIPS_XLEN-1:0]   write_data;
		logic [`MIPS_STRB_W-1:0] write_strb;
	} mem_req_t;

	// retired instruction report, wen on top and pc at the bottom
	typedef struct packed {
		logic                    wen;
		logic [`MIPS_REG_AW-1:0] waddr;
		logic [`MIPS_XLEN-1:0]   wdata;
		logic [`MIPS_XLEN-1:0]   pc;
	} retire_t;

endpackage

`default_nettype wire

/* verilog/mips_reg_file.sv */
`timescale 1ns/100ps
`default_nettype none
`include "mips_macros.svh"

module mips_reg_file (
	input  wire                     clk,
	input  wire [`MIPS_REG_AW-1:0]  raddr1,
	input  wire [`MIPS_REG_AW-1:0]  raddr2,
	input  wire [`MIPS_REG_AW-1:0]  waddr,
	input  wire [`MIPS_XLEN-1:0]    wdata,
	input  wire                     wen,
	output logic [`MIPS_XLEN-1:0]   rdata1,
	output logic [`MIPS_XLEN-1:0]   rdata2
);

	logic [`MIPS_XLEN-1:0] regs [0:(1 << `MIPS_REG_AW)-1];

	// r0 never takes a write
	always_ff @(posedge clk) begin
		if (wen && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

	// combinational reads, r0 forced to zero
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* verilog/mips_decoder.sv */
`timescale 1ns/100ps
`default_nettype none
`include "mips_macros.svh"

module mips_decoder (
	input  wire                   clk,
	input  wire [`MIPS_XLEN-1:0]  instruction,
	input  wire                   inst_fire,
	output mips_pkg::decoded_t    decoded
);

	logic [`MIPS_XLEN-1:0] ir;
	mips_pkg::funct_t funct;
	logic legal;

	// instruction register, loads when the response is taken
	always_ff @(posedge clk) begin
		if (inst_fire) begin
			ir <= instruction;
		end
	end

	assign funct = mips_pkg::funct_t'(ir[5:0]);

	always_comb begin
		// plain fields straight from the word
		decoded.opcode       = mips_pkg::opcode_t'(ir[31:26]);
		decoded.rs           = ir[25:21];
		decoded.rt           = ir[20:16];
		decoded.imm16        = ir[15:0];
		decoded.jump_index   = ir[25:0];
		// defaults, an i-type arithmetic shape writing rt
		decoded.alu_op       = mips_pkg::alu_add;
		decoded.b_from_imm   = 1'b1;
		decoded.zero_ext     = 1'b0;
		decoded.link         = 1'b0;
		decoded.wb_en        = 1'b1;
		decoded.wb_addr      = ir[20:16];
		decoded.wb_sel       = mips_pkg::wb_alu;
		decoded.is_load      = 1'b0;
		decoded.is_store     = 1'b0;
		decoded.is_branch    = 1'b0;
		decoded.branch_ne    = 1'b0;
		decoded.is_jump      = 1'b0;
		decoded.jump_reg     = 1'b0;
		decoded.mem_size     = mips_pkg::size_word;
		decoded.mem_unsigned = 1'b0;
		decoded.is_nop       = ~|ir;
		legal                = 1'b1;
		case (decoded.opcode)
			mips_pkg::op_special: begin
				// r-type writes rd from rs op rt
				decoded.b_from_imm = 1'b0;
				decoded.wb_addr    = ir[15:11];
				case (funct)
					mips_pkg::fn_addu: decoded.alu_op = mips_pkg::alu_add;
					mips_pkg::fn_subu: decoded.alu_op = mips_pkg::alu_sub;
					mips_pkg::fn_and:  decoded.alu_op = mips_pkg::alu_and;
					mips_pkg::fn_or:   decoded.alu_op = mips_pkg::alu_or;
					mips_pkg::fn_xor:  decoded.alu_op = mips_pkg::alu_xor;
					mips_pkg::fn_nor:  decoded.alu_op = mips_pkg::alu_nor;
					mips_pkg::fn_slt:  decoded.alu_op = mips_pkg::alu_slt;
					mips_pkg::fn_sltu: decoded.alu_op = mips_pkg::alu_sltu;
					mips_pkg::fn_jr: begin
						decoded.wb_en    = 1'b0;
						decoded.is_jump  = 1'b1;
						decoded.jump_reg = 1'b1;
					end
					default: begin
						decoded.wb_en = 1'b0;
						legal         = 1'b0;
					end
				endcase
			end
			mips_pkg::op_j: begin
				decoded.wb_en   = 1'b0;
				decoded.is_jump = 1'b1;
			end
			mips_pkg::op_jal: begin
				// link value is formed by the alu in ex
				decoded.is_jump = 1'b1;
				decoded.link    = 1'b1;
				decoded.wb_addr = `MIPS_LINK_REG;
			end
			mips_pkg::op_beq, mips_pkg::op_bne: begin
				// compare by subtraction, zero flag decides
				decoded.alu_op     = mips_pkg::alu_sub;
				decoded.b_from_imm = 1'b0;
				decoded.wb_en      = 1'b0;
				decoded.is_branch  = 1'b1;
				decoded.branch_ne  = ir[26];
			end
			mips_pkg::op_addiu: decoded.alu_op = mips_pkg::alu_add;
			mips_pkg::op_slti:  decoded.alu_op = mips_pkg::alu_slt;
			mips_pkg::op_sltiu: decoded.alu_op = mips_pkg::alu_sltu;
			mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_xori: begin
				// logic immediates are zero extended
				decoded.zero_ext = 1'b1;
				decoded.alu_op   = mips_pkg::alu_op_t'({1'b0, ir[27:26]} + 3'd2);
			end
			mips_pkg::op_lui: decoded.wb_sel = mips_pkg::wb_upper;
			mips_pkg::op_lb, mips_pkg::op_lh, mips_pkg::op_lw,
			mips_pkg::op_lbu, mips_pkg::op_lhu: begin
				decoded.is_load      = 1'b1;
				decoded.wb_sel       = mips_pkg::wb_load;
				decoded.mem_size     = mips_pkg::mem_size_t'(ir[27:26]);
				decoded.mem_unsigned = ir[28];
			end
			mips_pkg::op_sb, mips_pkg::op_sh, mips_pkg::op_sw: begin
				decoded.wb_en    = 1'b0;
				decoded.is_store = 1'b1;
				decoded.mem_size = mips_pkg::mem_size_t'(ir[27:26]);
			end
			default: begin
				decoded.wb_en = 1'b0;
				legal         = 1'b0;
			end
		endcase
	end

	// a word taken in the previous cycle must be a nop or a supported instruction
	a_known_inst: assert property (@(posedge clk)
		$past(inst_fire) && !decoded.is_nop |-> legal);

endmodule

`default_nettype wire

/* verilog/mips_execute.sv */
`timescale 1ns/100ps
`default_nettype none
`include "mips_macros.svh"

module mips_execute (
	input  wire                          clk,
	input  wire                          rst,
	input  wire mips_pkg::state_t        state,
	input  wire [`MIPS_XLEN-1:0]         pc,
	input  wire mips_pkg::decoded_t      decoded,
	input  wire [`MIPS_XLEN-1:0]         rs_data,
	input  wire [`MIPS_XLEN-1:0]         rt_data,
	output logic [`MIPS_XLEN-1:0]        alu_result,
	output logic                         alu_zero,
	output logic [`MIPS_XLEN-1:0]        result_q
);

	logic [`MIPS_XLEN-1:0] a_q;
	logic [`MIPS_XLEN-1:0] b_q;
	mips_pkg::alu_op_t op_q;
	logic [`MIPS_XLEN-1:0] a_sel;
	logic [`MIPS_XLEN-1:0] b_sel;
	mips_pkg::alu_op_t op_sel;
	logic [`MIPS_XLEN-1:0] ext_imm;
	logic [`MIPS_XLEN-1:0] diff;
	logic signed_lt;
	logic fetch_add;

	assign ext_imm = decoded.zero_ext ? {16'b0, decoded.imm16} :
		{{16{decoded.imm16[15]}}, decoded.imm16};

	// operands latch at the end of id
	always_ff @(posedge clk) begin
		if (state == mips_pkg::st_id) begin
			// pc already points past the jal and one more word gives the link
			a_q <= decoded.link ? pc : rs_data;
			b_q <= decoded.link ? `MIPS_XLEN'(4) : (decoded.b_from_imm ? ext_imm : rt_data);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			op_q <= mips_pkg::alu_add;
		end else if (state == mips_pkg::st_id) begin
			op_q <= decoded.alu_op;
		end
	end

	// iw makes pc+4 and id makes the branch target
	assign fetch_add = (state == mips_pkg::st_iw) || (state == mips_pkg::st_id);
	assign a_sel  = fetch_add ? pc : a_q;
	assign b_sel  = (state == mips_pkg::st_iw) ? `MIPS_XLEN'(4) :
		(state == mips_pkg::st_id) ? {ext_imm[`MIPS_XLEN-3:0], 2'b00} : b_q;
	assign op_sel = fetch_add ? mips_pkg::alu_add : op_q;

	assign diff = a_sel - b_sel;
	// signs differ means the negative one is smaller
	assign signed_lt = (a_sel[`MIPS_XLEN-1] != b_sel[`MIPS_XLEN-1]) ?
		a_sel[`MIPS_XLEN-1] : diff[`MIPS_XLEN-1];

	always_comb begin
		case (op_sel)
			mips_pkg::alu_add: alu_result = a_sel + b_sel;
			mips_pkg::alu_sub: alu_result = diff;
			mips_pkg::alu_and: alu_result = a_sel & b_sel;
			mips_pkg::alu_or:  alu_result = a_sel | b_sel;
			mips_pkg::alu_xor: alu_result = a_sel ^ b_sel;
			mips_pkg::alu_nor: alu_result = ~(a_sel | b_sel);
			mips_pkg::alu_slt: alu_result = `MIPS_XLEN'(signed_lt);
			default:           alu_result = `MIPS_XLEN'(a_sel < b_sel);
		endcase
	end

	assign alu_zero = ~|alu_result;

	// result of every cycle is read by the next state
	always_ff @(posedge clk) begin
		result_q <= alu_result;
	end

	// ex runs a known operation captured in id
	a_ex_op: assert property (@(posedge clk) disable iff (rst)
		state == mips_pkg::st_ex |-> !$isunknown(op_q));

endmodule

`default_nettype wire

/* verilog/mips_controller.sv */
`timescale 1ns/100ps
`default_nettype none
`include "mips_macros.svh"

module mips_controller (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       inst_req_ready,
	input  wire                       inst_valid,
	input  wire                       mem_req_ready,
	input  wire                       read_data_valid,
	input  wire mips_pkg::decoded_t   decoded,
	input  wire [`MIPS_XLEN-1:0]      alu_result,
	input  wire [`MIPS_XLEN-1:0]      result_q,
	input  wire [`MIPS_XLEN-1:0]      rs_data,
	input  wire                       alu_zero,
	output mips_pkg::state_t          state,
	output logic [`MIPS_XLEN-1:0]     pc,
	output logic [`MIPS_XLEN-1:0]     retire_pc,
	output logic                      inst_req_valid,
	output logic                      inst_ready,
	output logic                      read_data_ready,
	output logic                      inst_fire,
	output logic                      mem_read,
	output logic                      mem_write
);

	mips_pkg::state_t next_state;
	logic take_branch;
	logic [`MIPS_XLEN-1:0] jump_target;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mips_pkg::st_rst;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			mips_pkg::st_rst: next_state = mips_pkg::st_if;
			// wait for the fetch address to be taken
			mips_pkg::st_if:
				next_state = inst_req_ready ? mips_pkg::st_iw : mips_pkg::st_if;
			mips_pkg::st_iw:
				next_state = inst_valid ? mips_pkg::st_id : mips_pkg::st_iw;
			// an all-zero word skips straight to the next fetch
			mips_pkg::st_id:
				next_state = decoded.is_nop ? mips_pkg::st_if : mips_pkg::st_ex;
			mips_pkg::st_ex: begin
				if (decoded.is_load) begin
					next_state = mips_pkg::st_ld;
				end else if (decoded.is_store) begin
					next_state = mips_pkg::st_st;
				end else if (decoded.wb_en) begin
					// arithmetic, lui and jal
					next_state = mips_pkg::st_wb;
				end else begin
					// branches, j and jr
					next_state = mips_pkg::st_if;
				end
			end
			mips_pkg::st_ld:
				next_state = mem_req_ready ? mips_pkg::st_rdw : mips_pkg::st_ld;
			mips_pkg::st_st:
				next_state = mem_req_ready ? mips_pkg::st_if : mips_pkg::st_st;
			mips_pkg::st_rdw:
				next_state = read_data_valid ? mips_pkg::st_wb : mips_pkg::st_rdw;
			mips_pkg::st_wb: next_state = mips_pkg::st_if;
			default: next_state = mips_pkg::st_rst;
		endcase
	end

	// channel strobes straight from the state
	assign inst_req_valid  = (state == mips_pkg::st_if);
	assign inst_ready      = (state == mips_pkg::st_rst) || (state == mips_pkg::st_iw);
	assign read_data_ready = (state == mips_pkg::st_rst) || (state == mips_pkg::st_rdw);
	assign inst_fire       = inst_ready && inst_valid;
	assign mem_read        = (state == mips_pkg::st_ld);
	assign mem_write       = (state == mips_pkg::st_st);

	// in ex the alu holds rs-rt, bne inverts the test
	assign take_branch = decoded.is_branch && (alu_zero ^ decoded.branch_ne);
	// pc is pc+4 here, its top nibble selects the region
	assign jump_target = decoded.jump_reg ? rs_data :
		{pc[`MIPS_XLEN-1:28], decoded.jump_index, 2'b00};

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `MIPS_RESET_PC;
		end else if (state == mips_pkg::st_iw && inst_valid) begin
			// alu forms pc+4 during iw
			pc <= alu_result;
		end else if (state == mips_pkg::st_ex) begin
			if (take_branch) begin
				// target computed in id
				pc <= result_q;
			end else if (decoded.is_jump) begin
				pc <= jump_target;
			end
		end
	end

	// address of the instruction in flight
	always_ff @(posedge clk) begin
		if (state == mips_pkg::st_if) begin
			retire_pc <= pc;
		end
	end

	a_state_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(state));

endmodule

`default_nettype wire

/* verilog/mips_result.sv */
`timescale 1ns/100ps
`default_nettype none
`include "mips_macros.svh"

module mips_result (
	input  wire                        clk,
	input  wire mips_pkg::state_t      state,
	input  wire mips_pkg::decoded_t    decoded,
	input  wire [`MIPS_XLEN-1:0]       result_q,
	input  wire [`MIPS_XLEN-1:0]       rt_data,
	input  wire [`MIPS_XLEN-1:0]       read_data,
	input  wire [`MIPS_XLEN-1:0]       retire_pc,
	input  wire                        read_fire,
	output logic [`MIPS_XLEN-1:0]      address,
	output logic [`MIPS_XLEN-1:0]      write_data,
	output logic [`MIPS_STRB_W-1:0]    write_strb,
	output mips_pkg::retire_t          retire
);

	logic [1:0] off;
	logic [`MIPS_XLEN-1:0] read_q;
	logic [7:0] load_byte;
	logic [15:0] load_half;
	logic [`MIPS_XLEN-1:0] load_val;
	logic [`MIPS_XLEN-1:0] wb_data;

	// byte offset within the word
	assign off     = result_q[1:0];
	assign address = {result_q[`MIPS_XLEN-1:2], 2'b00};

	// store lanes replicated, strobes pick the bytes
	always_comb begin
		case (decoded.mem_size)
			mips_pkg::size_byte: begin
				write_data = {4{rt_data[7:0]}};
				write_strb = 4'b0001 << off;
			end
			mips_pkg::size_half: begin
				write_data = {2{rt_data[15:0]}};
				write_strb = off[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				write_data = rt_data;
				write_strb = 4'b1111;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (read_fire) begin
			read_q <= read_data;
		end
	end

	// little endian lane extraction
	assign load_byte = read_q[{off, 3'b000} +: 8];
	assign load_half = off[1] ? read_q[31:16] : read_q[15:0];

	always_comb begin
		case (decoded.mem_size)
			mips_pkg::size_byte:
				load_val = {{24{load_byte[7] & ~decoded.mem_unsigned}}, load_byte};
			mips_pkg::size_half:
				load_val = {{16{load_half[15] & ~decoded.mem_unsigned}}, load_half};
			default: load_val = read_q;
		endcase
	end

	always_comb begin
		case (decoded.wb_sel)
			mips_pkg::wb_load:  wb_data = load_val;
			mips_pkg::wb_upper: wb_data = {decoded.imm16, 16'b0};
			default:            wb_data = result_q;
		endcase
	end

	// one pulse per register write, in wb only
	assign retire = {(state == mips_pkg::st_wb) && decoded.wb_en, decoded.wb_addr,
		wb_data, retire_pc};

	// a store always writes some byte, and holds its data while stalled
	a_store_lanes: assert property (@(posedge clk) state == mips_pkg::st_st |->
		write_strb != '0 && (!$past(state == mips_pkg::st_st) || $stable(write_data)));

endmodule

`default_nettype wire

/* verilog/mips_cpu.sv */
`timescale 1ns/100ps
`default_nettype none
`include "mips_macros.svh"

module mips_cpu (
	input  wire                       clk,
	input  wire                       rst,
	// instruction request
	output wire [`MIPS_XLEN-1:0]      pc,
	output wire                       inst_req_valid,
	input  wire                       inst_req_ready,
	// instruction response
	input  wire [`MIPS_XLEN-1:0]      instruction,
	input  wire                       inst_valid,
	output wire                       inst_ready,
	// data request
	output wire mips_pkg::mem_req_t   mem_req,
	input  wire                       mem_req_ready,
	// read response
	input  wire [`MIPS_XLEN-1:0]      read_data,
	input  wire                       read_data_valid,
	output wire                       read_data_ready,
	output wire mips_pkg::retire_t    retire
);

	wire mips_pkg::state_t state;
	wire mips_pkg::decoded_t decoded;
	wire [`MIPS_XLEN-1:0] retire_pc;
	wire [`MIPS_XLEN-1:0] alu_result;
	wire [`MIPS_XLEN-1:0] result_q;
	wire [`MIPS_XLEN-1:0] rs_data;
	wire [`MIPS_XLEN-1:0] rt_data;
	wire [`MIPS_XLEN-1:0] address;
	wire [`MIPS_XLEN-1:0] write_data;
	wire [`MIPS_STRB_W-1:0] write_strb;
	wire alu_zero;
	wire inst_fire;
	wire mem_read;
	wire mem_write;
	wire read_fire;

	// controller owns the strobes, result stage the payload
	assign mem_req   = {mem_read, mem_write, address, write_data, write_strb};
	assign read_fire = read_data_ready & read_data_valid;

	mips_controller i_mips_controller (
		.clk(clk), .rst(rst),
		.inst_req_ready(inst_req_ready), .inst_valid(inst_valid),
		.mem_req_ready(mem_req_ready), .read_data_valid(read_data_valid),
		.decoded(decoded), .alu_result(alu_result), .result_q(result_q),
		.rs_data(rs_data), .alu_zero(alu_zero),
		.state(state), .pc(pc), .retire_pc(retire_pc),
		.inst_req_valid(inst_req_valid), .inst_ready(inst_ready),
		.read_data_ready(read_data_ready), .inst_fire(inst_fire),
		.mem_read(mem_read), .mem_write(mem_write)
	);

	mips_decoder i_mips_decoder (
		.clk(clk), .instruction(instruction), .inst_fire(inst_fire), .decoded(decoded)
	);

	mips_execute i_mips_execute (
		.clk(clk), .rst(rst), .state(state), .pc(pc), .decoded(decoded),
		.rs_data(rs_data), .rt_data(rt_data),
		.alu_result(alu_result), .alu_zero(alu_zero), .result_q(result_q)
	);

	// write port fed from the retire report
	mips_reg_file i_mips_reg_file (
		.clk(clk), .raddr1(decoded.rs), .raddr2(decoded.rt),
		.waddr(retire.waddr), .wdata(retire.wdata), .wen(retire.wen),
		.rdata1(rs_data), .rdata2(rt_data)
	);

	mips_result i_mips_result (
		.clk(clk), .state(state), .decoded(decoded), .result_q(result_q),
		.rt_data(rt_data), .read_data(read_data), .retire_pc(retire_pc),
		.read_fire(read_fire), .address(address), .write_data(write_data),
		.write_strb(write_strb), .retire(retire)
	);

endmodule

`default_nettype wire

/* sim/tb_mips_cpu.sv */
`timescale 1ns/100ps
`default_nettype none
`include "mips_macros.svh"

module tb_mips_cpu;

	localparam int clk_period = 40;
	localparam int reset_cycles = 16;
	localparam int settle_cycles = 40;
	localparam int num_tests = 6;
	// instructions executed by all programs and the slowest path through the fsm
	localparam int program_insts = 80;
	localparam int worst_cpi = 24;
	localparam int run_cycles = program_insts * worst_cpi +
		num_tests * (reset_cycles + settle_cycles + 20);

	logic clk;
	logic rst;
	logic inst_req_ready;
	logic [`MIPS_XLEN-1:0] instruction;
	logic inst_valid;
	logic mem_req_ready;
	logic [`MIPS_XLEN-1:0] read_data;
	logic read_data_valid;
	logic [`MIPS_XLEN-1:0] pc;
	logic inst_req_valid;
	logic inst_ready;
	logic read_data_ready;
	mips_pkg::mem_req_t mem_req;
	mips_pkg::retire_t retire;

	logic [`MIPS_XLEN-1:0] imem [0:255];
	logic [`MIPS_XLEN-1:0] dmem [0:255];
	logic [31:0] lfsr;
	int load_ptr;
	int value_errors;
	int other_errors;

	mips_pkg::retire_t exp_ret[$];
	mips_pkg::retire_t got_ret[$];
	mips_pkg::mem_req_t exp_wr[$];
	mips_pkg::mem_req_t got_wr[$];
	logic [`MIPS_XLEN-1:0] exp_fetch[$];
	logic [`MIPS_XLEN-1:0] got_fetch[$];

	mips_cpu i_mips_cpu (
		.clk(clk), .rst(rst),
		.pc(pc), .inst_req_valid(inst_req_valid), .inst_req_ready(inst_req_ready),
		.instruction(instruction), .inst_valid(inst_valid), .inst_ready(inst_ready),
		.mem_req(mem_req), .mem_req_ready(mem_req_ready),
		.read_data(read_data), .read_data_valid(read_data_valid),
		.read_data_ready(read_data_ready), .retire(retire)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// galois lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// two bits give a delay of 0 to 3 cycles
	task automatic pick_delay(output int d);
		d = 0;
		for (int i = 0; i < 2; i++) begin
			lfsr = lfsr_step(lfsr);
			d = (d << 1) | lfsr[0];
		end
	endtask

	function automatic logic [31:0] r_word(mips_pkg::funct_t fn, int rd, int rs, int rt);
		return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
	endfunction

	function automatic logic [31:0] i_word(mips_pkg::opcode_t op, int rt, int rs, int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic logic [31:0] j_word(mips_pkg::opcode_t op, int idx);
		return {op, idx[25:0]};
	endfunction

	// instruction channel model takes the request then returns the word
	initial begin
		logic [`MIPS_XLEN-1:0] req_pc;
		int d;
		inst_req_ready = 1'b0;
		instruction = '0;
		inst_valid = 1'b0;
		forever begin
			@(negedge clk);
			if (inst_req_valid) begin
				if (inst_ready !== 1'b0) begin
					$display("inst_ready high while a fetch request waits at %0t", $time);
					other_errors++;
				end
				pick_delay(d);
				repeat (d) @(negedge clk);
				req_pc = pc;
				got_fetch.push_back(req_pc);
				inst_req_ready = 1'b1;
				@(negedge clk);
				inst_req_ready = 1'b0;
				pick_delay(d);
				repeat (d) @(negedge clk);
				instruction = imem[req_pc[9:2]];
				inst_valid = 1'b1;
				if (inst_ready !== 1'b1) begin
					$display("inst_ready low while the instruction word is offered at %0t", $time);
					other_errors++;
				end
				@(negedge clk);
				inst_valid = 1'b0;
			end
		end
	end

	// data channel model with byte strobes
	initial begin
		mips_pkg::mem_req_t req;
		int d;
		mem_req_ready = 1'b0;
		read_data = '0;
		read_data_valid = 1'b0;
		forever begin
			@(negedge clk);
			if (mem_req.read || mem_req.write) begin
				if (read_data_ready !== 1'b0) begin
					$display("read_data_ready high while a data request waits at %0t", $time);
					other_errors++;
				end
				pick_delay(d);
				repeat (d) @(negedge clk);
				req = mem_req;
				mem_req_ready = 1'b1;
				@(negedge clk);
				mem_req_ready = 1'b0;
				if (req.write) begin
					got_wr.push_back(req);
					for (int b = 0; b < 4; b++) begin
						if (req.write_strb[b]) begin
							dmem[req.address[9:2]][8*b +: 8] = req.write_data[8*b +: 8];
						end
					end
				end else begin
					pick_delay(d);
					repeat (d) @(negedge clk);
					read_data = dmem[req.address[9:2]];
					read_data_valid = 1'b1;
					if (read_data_ready !== 1'b1) begin
						$display("read_data_ready low while read data is offered at %0t", $time);
						other_errors++;
					end
					@(negedge clk);
					read_data_valid = 1'b0;
				end
			end
		end
	end

	// retire pulses are sampled where state is stable
	always @(negedge clk) begin
		if (!rst && retire.wen) begin
			got_ret.push_back(retire);
		end
	end

	initial begin
		#(run_cycles * clk_period);
		$display("watchdog expired before the tests finished");
		$display("TESTBENCH FAILED");
		$finish;
	end

	task automatic report_value(string name, logic [31:0] got, logic [31:0] exp);
		$display("Fail %0t %s got %h expected %h", $time, name, got, exp);
		value_errors++;
	endtask

	task automatic check_retire(mips_pkg::retire_t got, mips_pkg::retire_t exp);
		if (got.waddr !== exp.waddr) report_value("retire.waddr", got.waddr, exp.waddr);
		if (got.wdata !== exp.wdata) report_value("retire.wdata", got.wdata, exp.wdata);
		if (got.pc !== exp.pc) report_value("retire.pc", got.pc, exp.pc);
	endtask

	task automatic check_write(mips_pkg::mem_req_t got, mips_pkg::mem_req_t exp);
		if (got.read !== exp.read) report_value("mem_req.read", got.read, exp.read);
		if (got.address !== exp.address) report_value("mem_req.address", got.address, exp.address);
		if (got.write_data !== exp.write_data) begin
			report_value("mem_req.write_data", got.write_data, exp.write_data);
		end
		if (got.write_strb !== exp.write_strb) begin
			report_value("mem_req.write_strb", got.write_strb, exp.write_strb);
		end
	endtask

	// fill words jump to themselves and data depends on every address bit
	task automatic clear_test;
		for (int i = 0; i < 256; i++) begin
			imem[i] = j_word(mips_pkg::op_j, i);
			dmem[i] = (i * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;
		end
		exp_ret.delete();
		exp_wr.delete();
		exp_fetch.delete();
		load_ptr = 0;
	endtask

	task automatic put(logic [31:0] w);
		imem[load_ptr] = w;
		load_ptr++;
	endtask

	// instruction that must retire with the pc of its slot
	task automatic put_ret(logic [31:0] w, int waddr, logic [31:0] data);
		mips_pkg::retire_t r;
		r.wen = 1'b1;
		r.waddr = waddr[4:0];
		r.wdata = data;
		r.pc = load_ptr * 4;
		exp_ret.push_back(r);
		put(w);
	endtask

	task automatic expect_write(logic [31:0] addr, logic [31:0] data, logic [3:0] strb);
		mips_pkg::mem_req_t m;
		m.read = 1'b0;
		m.write = 1'b1;
		m.address = addr;
		m.write_data = data;
		m.write_strb = strb;
		exp_wr.push_back(m);
	endtask

	// after reset nothing may happen before the first fetch at the reset address
	task automatic start_core;
		int n;
		rst = 1'b1;
		repeat (reset_cycles) @(negedge clk);
		got_ret.delete();
		got_wr.delete();
		got_fetch.delete();
		rst = 1'b0;
		n = 0;
		while (!inst_req_valid && n < 20) begin
			if (mem_req.read || mem_req.write || retire.wen) begin
				$display("memory strobe or retire pulse seen before the first fetch at %0t", $time);
				other_errors++;
			end
			@(negedge clk);
			n++;
		end
		if (!inst_req_valid) begin
			$display("no instruction request after reset");
			other_errors++;
		end else if (pc !== `MIPS_RESET_PC) begin
			report_value("pc", pc, `MIPS_RESET_PC);
		end
	endtask

	task automatic run_and_check(string name);
		start_core();
		while (got_ret.size() < exp_ret.size() || got_wr.size() < exp_wr.size() ||
			got_fetch.size() < exp_fetch.size()) begin
			@(negedge clk);
		end
		repeat (settle_cycles) @(negedge clk);
		if (got_ret.size() != exp_ret.size() || got_wr.size() != exp_wr.size()) begin
			$display("%s: saw %0d retires and %0d writes, expected %0d and %0d", name,
				got_ret.size(), got_wr.size(), exp_ret.size(), exp_wr.size());
			other_errors++;
		end
		for (int i = 0; i < exp_ret.size() && i < got_ret.size(); i++) begin
			check_retire(got_ret[i], exp_ret[i]);
		end
		for (int i = 0; i < exp_wr.size() && i < got_wr.size(); i++) begin
			check_write(got_wr[i], exp_wr[i]);
		end
		for (int i = 0; i < exp_fetch.size(); i++) begin
			if (got_fetch[i] !== exp_fetch[i]) report_value("pc", got_fetch[i], exp_fetch[i]);
		end
	endtask

	task automatic test_arith;
		clear_test();
		put_ret(i_word(mips_pkg::op_lui, 1, 0, 'hFFFF), 1, 32'hFFFF_0000);
		put_ret(i_word(mips_pkg::op_ori, 1, 1, 'hFFFB), 1, 32'hFFFF_FFFB);
		put_ret(i_word(mips_pkg::op_addiu, 2, 0, 3), 2, 32'd3);
		put_ret(r_word(mips_pkg::fn_addu, 3, 1, 2), 3, -32'sd5 + 32'sd3);
		put_ret(r_word(mips_pkg::fn_subu, 4, 2, 1), 4, 32'd8);
		put_ret(r_word(mips_pkg::fn_and, 5, 1, 2), 5, 32'hFFFF_FFFB & 32'd3);
		put_ret(r_word(mips_pkg::fn_or, 6, 1, 2), 6, 32'hFFFF_FFFB | 32'd3);
		put_ret(r_word(mips_pkg::fn_xor, 7, 1, 2), 7, 32'hFFFF_FFFB ^ 32'd3);
		put_ret(r_word(mips_pkg::fn_nor, 8, 1, 2), 8, ~(32'hFFFF_FFFB | 32'd3));
		// -5 against 3 as signed then unsigned
		put_ret(r_word(mips_pkg::fn_slt, 9, 1, 2), 9, 32'd1);
		put_ret(r_word(mips_pkg::fn_sltu, 10, 1, 2), 10, 32'd0);
		put_ret(i_word(mips_pkg::op_slti, 11, 1, -4), 11, 32'd1);
		put_ret(i_word(mips_pkg::op_sltiu, 12, 2, -1), 12, 32'd1);
		put_ret(i_word(mips_pkg::op_andi, 13, 1, 'h8F0F), 13, 32'hFFFF_FFFB & 32'h8F0F);
		put_ret(i_word(mips_pkg::op_xori, 14, 1, 'h00FF), 14, 32'hFFFF_FFFB ^ 32'h00FF);
		// r0 reports the value but keeps reading zero
		put_ret(i_word(mips_pkg::op_addiu, 0, 2, 7), 0, 32'd10);
		put_ret(r_word(mips_pkg::fn_addu, 15, 0, 2), 15, 32'd3);
		run_and_check("arith");
	endtask

	task automatic test_stores;
		clear_test();
		put_ret(i_word(mips_pkg::op_lui, 1, 0, 'h1122), 1, 32'h1122_0000);
		put_ret(i_word(mips_pkg::op_ori, 1, 1, 'h3344), 1, 32'h1122_3344);
		put_ret(i_word(mips_pkg::op_addiu, 2, 0, 'h100), 2, 32'h100);
		for (int k = 0; k < 4; k++) begin
			put(i_word(mips_pkg::op_sb, 1, 2, k));
			expect_write(32'h100, 32'h4444_4444, 4'b0001 << k);
		end
		put(i_word(mips_pkg::op_sh, 1, 2, 0));
		expect_write(32'h100, 32'h3344_3344, 4'b0011);
		put(i_word(mips_pkg::op_sh, 1, 2, 2));
		expect_write(32'h100, 32'h3344_3344, 4'b1100);
		put(i_word(mips_pkg::op_sw, 1, 2, 4));
		expect_write(32'h104, 32'h1122_3344, 4'b1111);
		run_and_check("stores");
	endtask

	task automatic test_loads;
		clear_test();
		dmem[8'h80] = 32'h80F1_7F82;
		put_ret(i_word(mips_pkg::op_addiu, 2, 0, 'h200), 2, 32'h200);
		put_ret(i_word(mips_pkg::op_lb, 3, 2, 0), 3, 32'hFFFF_FF82);
		put_ret(i_word(mips_pkg::op_lb, 4, 2, 1), 4, 32'h0000_007F);
		put_ret(i_word(mips_pkg::op_lb, 5, 2, 2), 5, 32'hFFFF_FFF1);
		put_ret(i_word(mips_pkg::op_lb, 6, 2, 3), 6, 32'hFFFF_FF80);
		put_ret(i_word(mips_pkg::op_lbu, 7, 2, 0), 7, 32'h0000_0082);
		put_ret(i_word(mips_pkg::op_lbu, 8, 2, 3), 8, 32'h0000_0080);
		put_ret(i_word(mips_pkg::op_lh, 9, 2, 0), 9, 32'h0000_7F82);
		put_ret(i_word(mips_pkg::op_lh, 10, 2, 2), 10, 32'hFFFF_80F1);
		put_ret(i_word(mips_pkg::op_lhu, 11, 2, 2), 11, 32'h0000_80F1);
		put_ret(i_word(mips_pkg::op_lw, 12, 2, 0), 12, 32'h80F1_7F82);
		run_and_check("loads");
	endtask

	task automatic test_branches;
		logic [31:0] path [12];
		clear_test();
		path = '{0, 4, 8, 20, 24, 28, 40, 80, 84, 96, 120, 124};
		put_ret(i_word(mips_pkg::op_addiu, 1, 0, 5), 1, 32'd5);
		put_ret(i_word(mips_pkg::op_addiu, 2, 0, 5), 2, 32'd5);
		// taken beq skips two words
		put(i_word(mips_pkg::op_beq, 2, 1, 2));
		put(i_word(mips_pkg::op_addiu, 3, 0, 1));
		put(i_word(mips_pkg::op_addiu, 3, 0, 2));
		put(i_word(mips_pkg::op_bne, 2, 1, 5));
		put(i_word(mips_pkg::op_beq, 0, 1, 5));
		put(i_word(mips_pkg::op_bne, 0, 1, 2));
		put(i_word(mips_pkg::op_addiu, 3, 0, 3));
		put(i_word(mips_pkg::op_addiu, 3, 0, 4));
		// link is the jal address plus 8
		put_ret(j_word(mips_pkg::op_jal, 20), 31, 32'd48);
		load_ptr = 20;
		put_ret(i_word(mips_pkg::op_addiu, 4, 0, 96), 4, 32'd96);
		put(r_word(mips_pkg::fn_jr, 0, 4, 0));
		load_ptr = 24;
		put(j_word(mips_pkg::op_j, 30));
		load_ptr = 30;
		put_ret(i_word(mips_pkg::op_addiu, 5, 0, 7), 5, 32'd7);
		foreach (path[i]) exp_fetch.push_back(path[i]);
		run_and_check("branches");
	endtask

	task automatic test_nop;
		clear_test();
		put_ret(i_word(mips_pkg::op_addiu, 1, 0, 1), 1, 32'd1);
		put(32'h0000_0000);
		put_ret(i_word(mips_pkg::op_addiu, 2, 0, 2), 2, 32'd2);
		exp_fetch = '{0, 4, 8, 12};
		run_and_check("nop");
	endtask

	initial begin
		rst = 1'b1;
		lfsr = 32'h5165_5888;
		value_errors = 0;
		other_errors = 0;
		test_arith();
		test_stores();
		// second pass sees other channel delays
		test_loads();
		test_loads();
		test_branches();
		test_nop();
		$display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
verilog/mips_pkg.sv
verilog/mips_reg_file.sv
verilog/mips_decoder.sv
verilog/mips_execute.sv
verilog/mips_controller.sv
verilog/mips_result.sv
verilog/mips_cpu.sv
sim/tb_mips_cpu.sv
